/* bench/id_model.svh */
// Reference model of the RV32I decode stage
// Immediates, legality, operator and next ID/EX pipe contents
`ifndef ID_MODEL_SVH
`define ID_MODEL_SVH

// Sign extended immediate formats
function automatic word_t i_immediate(word_t ins);
  return {{20{ins[31]}}, ins[31:20]};
endfunction

function automatic word_t u_immediate(word_t ins);
  return {ins[31:12], 12'h000};
endfunction

function automatic word_t sb_immediate(word_t ins);
  return {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
endfunction

function automatic word_t uj_immediate(word_t ins);
  return {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
endfunction

// RV32I encodings kept by the stage
function automatic logic legal_encoding(word_t ins);
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = ins[14:12];
  f7 = ins[31:25];
  case (ins[6:0])
    OPCODE_OP:    return (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
    OPCODE_OPIMM: begin
      if (f3 == 3'd1) return f7 == 7'h00;
      return (f3 != 3'd5) || (f7 == 7'h00) || (f7 == 7'h20);
    end
    OPCODE_LUI, OPCODE_AUIPC, OPCODE_JAL: return 1'b1;
    OPCODE_JALR:   return f3 == 3'd0;
    OPCODE_BRANCH: return (f3 != 3'd2) && (f3 != 3'd3);
    default:       return 1'b0;
  endcase
endfunction

function automatic alu_op_e expected_operator(word_t ins);
  logic [2:0] f3;
  f3 = ins[14:12];
  if (!legal_encoding(ins)) return ALU_ADD;
  // Branch compares by funct3
  if (ins[6:0] == OPCODE_BRANCH) begin
    case (f3)
      3'd0:    return ALU_EQ;
      3'd1:    return ALU_NE;
      3'd4:    return ALU_LT;
      3'd5:    return ALU_GE;
      3'd6:    return ALU_LTU;
      default: return ALU_GEU;
    endcase
  end
  // LUI, AUIPC and jumps all add
  if (ins[6:0] != OPCODE_OP && ins[6:0] != OPCODE_OPIMM) return ALU_ADD;
  case (f3)
    3'd0:    return (ins[6:0] == OPCODE_OP && ins[30]) ? ALU_SUB : ALU_ADD;
    3'd1:    return ALU_SLL;
    3'd2:    return ALU_SLT;
    3'd3:    return ALU_SLTU;
    3'd4:    return ALU_XOR;
    3'd5:    return ins[30] ? ALU_SRA : ALU_SRL;
    3'd6:    return ALU_OR;
    default: return ALU_AND;
  endcase
endfunction

function automatic word_t forwarded_value(fw_sel_e sel, word_t rf, word_t ex, word_t wb);
  case (sel)
    SEL_FW_EX: return ex;
    SEL_FW_WB: return wb;
    default:   return rf;
  endcase
endfunction

// JAL, JALR with bit 0 cleared, else the branch target
function automatic word_t expected_target(if_id_pipe_t ifid, word_t rs1);
  word_t sum;
  sum = rs1 + i_immediate(ifid.instr);
  if (ifid.instr[6:0] == OPCODE_JAL) return ifid.pc + uj_immediate(ifid.instr);
  if (legal_encoding(ifid.instr) && ifid.instr[6:0] == OPCODE_JALR) return {sum[31:1], 1'b0};
  return ifid.pc + sb_immediate(ifid.instr);
endfunction

// Register state after the next edge, gated fields hold their old value
function automatic id_ex_pipe_t advance_pipe(id_ex_pipe_t prev, if_id_pipe_t ifid, word_t rs1,
                                             word_t rs2, logic kill, logic ready);
  id_ex_pipe_t nxt;
  logic [6:0]  opc;
  logic        ok;
  nxt = prev;
  opc = ifid.instr[6:0];
  ok  = legal_encoding(ifid.instr);
  if (!(ifid.instr_valid && !kill && ready)) begin
    // Bubble clears valid, stall holds everything
    if (ready) nxt.instr_valid = 1'b0;
    return nxt;
  end
  nxt.instr_valid  = 1'b1;
  nxt.pc           = ifid.pc;
  nxt.instr        = ifid.instr;
  nxt.alu_operator = expected_operator(ifid.instr);
  nxt.illegal_insn = !ok;
  nxt.rf_we        = ok && (opc != OPCODE_BRANCH);
  nxt.jump         = ok && (opc == OPCODE_JAL || opc == OPCODE_JALR);
  nxt.branch_in_ex = ok && (opc == OPCODE_BRANCH);
  if (nxt.rf_we) nxt.rf_waddr = ifid.instr[11:7];
  if (ok) begin
    case (opc)
      OPCODE_LUI: begin
        nxt.alu_operand_a = '0;
        nxt.alu_operand_b = u_immediate(ifid.instr);
      end
      OPCODE_AUIPC: begin
        nxt.alu_operand_a = ifid.pc;
        nxt.alu_operand_b = u_immediate(ifid.instr);
      end
      // Link value PC + 4
      OPCODE_JAL, OPCODE_JALR: begin
        nxt.alu_operand_a = ifid.pc;
        nxt.alu_operand_b = 32'd4;
      end
      OPCODE_OPIMM: begin
        nxt.alu_operand_a = rs1;
        nxt.alu_operand_b = i_immediate(ifid.instr);
      end
      default: begin
        nxt.alu_operand_a = rs1;
        nxt.alu_operand_b = rs2;
      end
    endcase
    if (opc == OPCODE_BRANCH) nxt.operand_c = ifid.pc + sb_immediate(ifid.instr);
  end
  return nxt;
endfunction

`endif

/* bench/id_stage_tb.sv */
// Testbench for the RV32I decode stage
// LFSR driven stimulus checked against a reference model after every edge
`timescale 1ns/1ns

module id_stage_tb;
  import id_pkg::*;

  localparam int NUM_CYCLES   = 3000;
  localparam int RESET_CYCLES = 16;
  localparam int CLK_PERIOD   = 100;
  localparam logic [6:0] KEPT_OPCODES [7] = '{OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI,
    OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR, OPCODE_BRANCH};

  logic        clk;
  logic        rst_n;
  if_id_pipe_t if_id;
  ctrl_byp_t   byp;
  word_t       rf_rdata_a;
  word_t       rf_rdata_b;
  word_t       wdata_ex;
  word_t       wdata_wb;
  logic        kill_id;
  logic        ex_ready;
  reg_addr_t   raddr_a;
  reg_addr_t   raddr_b;
  word_t       jmp_target;
  logic        id_ready;
  id_ex_pipe_t id_ex_pipe;

  // Model state
  word_t       lfsr_state;
  id_ex_pipe_t exp_pipe;

  `include "id_model.svh"

  id_stage i_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .if_id_pipe_i  (if_id),
    .ctrl_byp_i    (byp),
    .rf_rdata_a_i  (rf_rdata_a),
    .rf_rdata_b_i  (rf_rdata_b),
    .rf_wdata_ex_i (wdata_ex),
    .rf_wdata_wb_i (wdata_wb),
    .kill_id_i     (kill_id),
    .ex_ready_i    (ex_ready),
    .rf_raddr_a_o  (raddr_a),
    .rf_raddr_b_o  (raddr_b),
    .jmp_target_o  (jmp_target),
    .id_ready_o    (id_ready),
    .id_ex_pipe_o  (id_ex_pipe)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random numbers and checks
  //////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit taken
  function automatic word_t lfsr_bits(int nbits);
    word_t val;
    val = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  task automatic fail_run(string why);
    $display("%s", why);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic compare_word(string name, word_t act, word_t exp);
    if (act !== exp) fail_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp));
  endtask

  task automatic compare_addr(string name, reg_addr_t act, reg_addr_t exp);
    if (act !== exp) fail_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp));
  endtask

  task automatic compare_pipe(string name, id_ex_pipe_t act, id_ex_pipe_t exp);
    if (act !== exp) fail_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp));
  endtask

  task automatic compare_ready(string name, logic act, logic exp);
    if (act !== exp) fail_run($sformatf("MISMATCH %s: got 0x%h expected 0x%h", name, act, exp));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus and per-cycle checks
  //////////////////////////////////////////////////////////////////////

  task automatic drive_inputs();
    if_id_pipe_t nxt;
    ctrl_byp_t   nbyp;
    word_t       r;
    nxt = if_id;
    // Upstream holds a stalled item
    if (!(if_id.instr_valid && !kill_id && !ex_ready)) begin
      r         = lfsr_bits(3);
      nxt.instr = lfsr_bits(32);
      if (r[2:0] != 3'd7) begin
        nxt.instr[6:0] = KEPT_OPCODES[r[2:0]];
        // Mostly legal funct7 with the odd random one
        r = lfsr_bits(2);
        if (r[1:0] != 2'd3) nxt.instr[31:25] = r[0] ? 7'h20 : 7'h00;
        if (nxt.instr[6:0] == OPCODE_JALR && lfsr_bits(1) == 1) nxt.instr[14:12] = 3'd0;
      end
      nxt.pc          = lfsr_bits(32);
      nxt.instr_valid = (lfsr_bits(2) != 0);
    end
    r = lfsr_bits(2) % 3;
    nbyp.operand_a_fw_sel = fw_sel_e'(r[1:0]);
    r = lfsr_bits(2) % 3;
    nbyp.operand_b_fw_sel = fw_sel_e'(r[1:0]);
    if_id      <= nxt;
    byp        <= nbyp;
    kill_id    <= (lfsr_bits(3) == 0);
    ex_ready   <= (lfsr_bits(2) != 0);
    rf_rdata_a <= lfsr_bits(32);
    rf_rdata_b <= lfsr_bits(32);
    wdata_ex   <= lfsr_bits(32);
    wdata_wb   <= lfsr_bits(32);
  endtask

  // Runs mid-cycle where inputs and outputs are settled
  task automatic check_cycle();
    word_t rs1;
    word_t rs2;
    rs1 = forwarded_value(byp.operand_a_fw_sel, rf_rdata_a, wdata_ex, wdata_wb);
    rs2 = forwarded_value(byp.operand_b_fw_sel, rf_rdata_b, wdata_ex, wdata_wb);
    compare_pipe("id_ex_pipe_o", id_ex_pipe, exp_pipe);
    compare_addr("rf_raddr_a_o", raddr_a, if_id.instr[19:15]);
    compare_addr("rf_raddr_b_o", raddr_b, if_id.instr[24:20]);
    compare_word("jmp_target_o", jmp_target, expected_target(if_id, rs1));
    compare_ready("id_ready_o", id_ready, kill_id || ex_ready);
    exp_pipe = advance_pipe(exp_pipe, if_id, rs1, rs2, kill_id, ex_ready);
  endtask

  // Watchdog
  initial begin
    #((NUM_CYCLES + RESET_CYCLES + 10) * CLK_PERIOD + 1000);
    fail_run("Watchdog timeout: the test did not complete in the expected time");
  end

  initial begin
    lfsr_state = 32'ha7f71027;
    exp_pipe   = '0;
    rst_n      <= 1'b0;
    if_id      <= '0;
    byp        <= '0;
    rf_rdata_a <= '0;
    rf_rdata_b <= '0;
    wdata_ex   <= '0;
    wdata_wb   <= '0;
    kill_id    <= 1'b0;
    ex_ready   <= 1'b0;

    // All outputs of the register cleared while in reset
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    compare_pipe("id_ex_pipe_o in reset", id_ex_pipe, '0);
    @(posedge clk);
    rst_n <= 1'b1;

    for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
      drive_inputs();
      @(negedge clk);
      check_cycle();
      @(posedge clk);
    end

    $display("*** PASSED ***");
    $finish;
  end

endmodule

/* hw/id_decoder.sv */
// RV32I instruction decoder
// Maps opcode, funct3 and funct7 onto ALU operator, operand selects and flags
`timescale 1ns/1ns

module id_decoder (
  input  id_pkg::word_t   instr_i,
  output id_pkg::decode_t dec_o
);
  import id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  always_comb begin
    // Defaults describe an instruction that uses nothing
    dec_o.alu_operator  = ALU_ADD;
    dec_o.op_a_sel      = OP_A_NONE;
    dec_o.op_b_sel      = OP_B_NONE;
    dec_o.op_c_sel      = OP_C_NONE;
    dec_o.imm_b_sel     = IMMB_I;
    dec_o.rf_we         = 1'b0;
    dec_o.ctrl_transfer = CT_NONE;
    dec_o.illegal_insn  = 1'b0;
    illegal             = 1'b0;

    case (opcode)
      // Register-register ALU
      OPCODE_OP: begin
        dec_o.op_a_sel = OP_A_REGA_OR_FWD;
        dec_o.op_b_sel = OP_B_REGB_OR_FWD;
        dec_o.rf_we    = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: dec_o.alu_operator = ALU_ADD;
          {7'h20, 3'b000}: dec_o.alu_operator = ALU_SUB;
          {7'h00, 3'b001}: dec_o.alu_operator = ALU_SLL;
          {7'h00, 3'b010}: dec_o.alu_operator = ALU_SLT;
          {7'h00, 3'b011}: dec_o.alu_operator = ALU_SLTU;
          {7'h00, 3'b100}: dec_o.alu_operator = ALU_XOR;
          {7'h00, 3'b101}: dec_o.alu_operator = ALU_SRL;
          {7'h20, 3'b101}: dec_o.alu_operator = ALU_SRA;
          {7'h00, 3'b110}: dec_o.alu_operator = ALU_OR;
          {7'h00, 3'b111}: dec_o.alu_operator = ALU_AND;
          default:         illegal = 1'b1;
        endcase
      end

      // Register-immediate ALU, shifts keep funct7 inside the I immediate
      OPCODE_OPIMM: begin
        dec_o.op_a_sel  = OP_A_REGA_OR_FWD;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_I;
        dec_o.rf_we     = 1'b1;
        case (funct3)
          3'b000: dec_o.alu_operator = ALU_ADD;
          3'b010: dec_o.alu_operator = ALU_SLT;
          3'b011: dec_o.alu_operator = ALU_SLTU;
          3'b100: dec_o.alu_operator = ALU_XOR;
          3'b110: dec_o.alu_operator = ALU_OR;
          3'b111: dec_o.alu_operator = ALU_AND;
          3'b001: begin
            dec_o.alu_operator = ALU_SLL;
            illegal            = (funct7 != 7'h00);
          end
          default: begin
            // funct3 101 picks logical or arithmetic right shift
            dec_o.alu_operator = (funct7 == 7'h20) ? ALU_SRA : ALU_SRL;
            illegal            = (funct7 != 7'h00) && (funct7 != 7'h20);
          end
        endcase
      end

      // Upper immediate plus zero or PC
      OPCODE_LUI, OPCODE_AUIPC: begin
        dec_o.op_a_sel  = (opcode == OPCODE_LUI) ? OP_A_ZERO : OP_A_CURRPC;
        dec_o.op_b_sel  = OP_B_IMM;
        dec_o.imm_b_sel = IMMB_U;
        dec_o.rf_we     = 1'b1;
      end

      // Jumps compute the link value PC + 4 in the ALU
      OPCODE_JAL, OPCODE_JALR: begin
        dec_o.op_a_sel      = OP_A_CURRPC;
        dec_o.op_b_sel      = OP_B_IMM;
        dec_o.imm_b_sel     = IMMB_PCINCR;
        dec_o.rf_we         = 1'b1;
        dec_o.ctrl_transfer = (opcode == OPCODE_JAL) ? CT_JAL : CT_JALR;
        illegal             = (opcode == OPCODE_JALR) && (funct3 != 3'b000);
      end

      // Compare rs1 with rs2, target travels in operand C
      OPCODE_BRANCH: begin
        dec_o.op_a_sel      = OP_A_REGA_OR_FWD;
        dec_o.op_b_sel      = OP_B_REGB_OR_FWD;
        dec_o.op_c_sel      = OP_C_BCH;
        dec_o.ctrl_transfer = CT_BRANCH;
        case (funct3)
          3'b000:  dec_o.alu_operator = ALU_EQ;
          3'b001:  dec_o.alu_operator = ALU_NE;
          3'b100:  dec_o.alu_operator = ALU_LT;
          3'b101:  dec_o.alu_operator = ALU_GE;
          3'b110:  dec_o.alu_operator = ALU_LTU;
          3'b111:  dec_o.alu_operator = ALU_GEU;
          default: illegal = 1'b1;
        endcase
      end

      default: illegal = 1'b1;
    endcase

    // Illegal encodings fall back to a do-nothing instruction
    if (illegal) begin
      dec_o.alu_operator  = ALU_ADD;
      dec_o.op_a_sel      = OP_A_NONE;
      dec_o.op_b_sel      = OP_B_NONE;
      dec_o.op_c_sel      = OP_C_NONE;
      dec_o.imm_b_sel     = IMMB_I;
      dec_o.rf_we         = 1'b0;
      dec_o.ctrl_transfer = CT_NONE;
      dec_o.illegal_insn  = 1'b1;
    end
  end

endmodule

/* hw/id_ex_register.sv */
// ID/EX pipeline register with the stage valid/ready handshake
// Merges decoder and operand unit results into the EX pipe
`timescale 1ns/1ns

module id_ex_register (
  input  logic                clk,
  input  logic                rst_n,
  input  id_pkg::decode_t     dec_i,
  input  id_pkg::operands_t   ops_i,
  input  id_pkg::if_id_pipe_t if_id_i,
  input  id_pkg::reg_addr_t   rd_i,
  input  logic                kill_id_i,
  input  logic                ex_ready_i,
  output logic                id_ready_o,
  output id_pkg::id_ex_pipe_t pipe_o
);
  import id_pkg::*;

  logic id_valid;
  logic transfer;

  // Item offered unless killed
  assign id_valid   = if_id_i.instr_valid && !kill_id_i;
  assign transfer   = id_valid && ex_ready_i;
  // A kill drops the item, so ID can always take the next one
  assign id_ready_o = kill_id_i || ex_ready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pipe_o <= '0;
    end else if (transfer) begin
      pipe_o.instr_valid  <= 1'b1;
      pipe_o.pc           <= if_id_i.pc;
      pipe_o.instr        <= if_id_i.instr;
      pipe_o.alu_operator <= dec_i.alu_operator;

      // Operands only load when used
      if (dec_i.op_a_sel != OP_A_NONE) begin
        pipe_o.alu_operand_a <= ops_i.operand_a;
      end
      if (dec_i.op_b_sel != OP_B_NONE) begin
        pipe_o.alu_operand_b <= ops_i.operand_b;
      end
      if (dec_i.op_c_sel != OP_C_NONE) begin
        pipe_o.operand_c <= ops_i.operand_c;
      end

      pipe_o.rf_we <= dec_i.rf_we;
      if (dec_i.rf_we) begin
        pipe_o.rf_waddr <= rd_i;
      end

      // Control transfer kind for EX
      pipe_o.jump         <= (dec_i.ctrl_transfer == CT_JAL) ||
                             (dec_i.ctrl_transfer == CT_JALR);
      pipe_o.branch_in_ex <= (dec_i.ctrl_transfer == CT_BRANCH);
      pipe_o.illegal_insn <= dec_i.illegal_insn;
    end else if (ex_ready_i) begin
      // Bubble into EX
      pipe_o.instr_valid <= 1'b0;
    end
  end

endmodule

/* hw/id_operand_unit.sv */
// Operand unit of the decode stage
// Immediates, forwarding muxes, operands A/B/C and jump target
`timescale 1ns/1ns

module id_operand_unit (
  input  id_pkg::decode_t   dec_i,
  input  id_pkg::word_t     instr_i,
  input  id_pkg::word_t     pc_i,
  input  id_pkg::ctrl_byp_t byp_i,
  input  id_pkg::word_t     rf_rdata_a_i,
  input  id_pkg::word_t     rf_rdata_b_i,
  input  id_pkg::word_t     rf_wdata_ex_i,
  input  id_pkg::word_t     rf_wdata_wb_i,
  output id_pkg::operands_t ops_o,
  output id_pkg::word_t     jmp_target_o
);
  import id_pkg::*;

  word_t imm_i_type;
  word_t imm_u_type;
  word_t imm_sb_type;
  word_t imm_uj_type;
  word_t imm_b;
  word_t operand_a_fw;
  word_t operand_b_fw;
  word_t bch_target;
  word_t jalr_sum;

  //////////////////////////////////////////////////////////////////////
  // Immediates
  //////////////////////////////////////////////////////////////////////

  // Sign bit is always instr[31]
  assign imm_i_type  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_u_type  = {instr_i[31:12], 12'b0};
  assign imm_sb_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
  assign imm_uj_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20],
                        instr_i[30:21], 1'b0};

  always_comb begin
    case (dec_i.imm_b_sel)
      IMMB_U:      imm_b = imm_u_type;
      IMMB_PCINCR: imm_b = PC_INCR;
      default:     imm_b = imm_i_type;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////////////////////////

  // rs1 path, also used by JALR
  always_comb begin
    case (byp_i.operand_a_fw_sel)
      SEL_FW_EX: operand_a_fw = rf_wdata_ex_i;
      SEL_FW_WB: operand_a_fw = rf_wdata_wb_i;
      default:   operand_a_fw = rf_rdata_a_i;
    endcase
  end

  // rs2 path
  always_comb begin
    case (byp_i.operand_b_fw_sel)
      SEL_FW_EX: operand_b_fw = rf_wdata_ex_i;
      SEL_FW_WB: operand_b_fw = rf_wdata_wb_i;
      default:   operand_b_fw = rf_rdata_b_i;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Operand muxes and targets
  //////////////////////////////////////////////////////////////////////

  assign bch_target = pc_i + imm_sb_type;
  assign jalr_sum   = operand_a_fw + imm_i_type;

  always_comb begin
    case (dec_i.op_a_sel)
      OP_A_CURRPC: ops_o.operand_a = pc_i;
      OP_A_ZERO:   ops_o.operand_a = '0;
      default:     ops_o.operand_a = operand_a_fw;
    endcase
    // NONE selects fall through to the register path and are not loaded
    ops_o.operand_b = (dec_i.op_b_sel == OP_B_IMM) ? imm_b : operand_b_fw;
    ops_o.operand_c = (dec_i.op_c_sel == OP_C_BCH) ? bch_target : operand_b_fw;
  end

  // JALR clears bit 0 of the sum
  always_comb begin
    case (dec_i.ctrl_transfer)
      CT_JAL:  jmp_target_o = pc_i + imm_uj_type;
      CT_JALR: jmp_target_o = {jalr_sum[31:1], 1'b0};
      default: jmp_target_o = bch_target;
    endcase
  end

endmodule

/* hw/id_pkg.sv */
// Shared definitions for the RV32I instruction decode stage
// Opcodes, field positions, operand selects and pipeline structs
package id_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths and encodings
  //////////////////////////////////////////////////////////////////////

  // Data, address and instruction word
  typedef logic [31:0] word_t;
  // Register file index
  typedef logic [4:0]  reg_addr_t;

  // Major opcodes of the kept instruction groups
  localparam logic [6:0] OPCODE_OP     = 7'h33;
  localparam logic [6:0] OPCODE_OPIMM  = 7'h13;
  localparam logic [6:0] OPCODE_LUI    = 7'h37;
  localparam logic [6:0] OPCODE_AUIPC  = 7'h17;
  localparam logic [6:0] OPCODE_JAL    = 7'h6f;
  localparam logic [6:0] OPCODE_JALR   = 7'h67;
  localparam logic [6:0] OPCODE_BRANCH = 7'h63;

  // Register fields inside the instruction word
  localparam int REG_S1_MSB = 19;
  localparam int REG_S1_LSB = 15;
  localparam int REG_S2_MSB = 24;
  localparam int REG_S2_LSB = 20;
  localparam int REG_D_MSB  = 11;
  localparam int REG_D_LSB  = 7;

  // Link increment for uncompressed jumps
  localparam word_t PC_INCR = 32'd4;

  // ALU operations, branch compares at the top
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR,  ALU_AND,
    ALU_EQ,  ALU_NE,  ALU_LT,  ALU_GE,  ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REGA_OR_FWD, OP_A_CURRPC, OP_A_ZERO, OP_A_NONE} op_a_sel_e;
  typedef enum logic [1:0] {OP_B_REGB_OR_FWD, OP_B_IMM, OP_B_NONE} op_b_sel_e;
  typedef enum logic [1:0] {OP_C_REGB_OR_FWD, OP_C_BCH, OP_C_NONE} op_c_sel_e;
  typedef enum logic [1:0] {IMMB_I, IMMB_U, IMMB_PCINCR} imm_b_sel_e;
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;
  typedef enum logic [1:0] {CT_NONE, CT_JAL, CT_JALR, CT_BRANCH} ctrl_transfer_e;

  //////////////////////////////////////////////////////////////////////
  // Pipeline structs
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic  instr_valid;
    word_t pc;
    word_t instr;
  } if_id_pipe_t;

  // Forward selects from the hazard logic
  typedef struct packed {
    fw_sel_e operand_a_fw_sel;
    fw_sel_e operand_b_fw_sel;
  } ctrl_byp_t;

  typedef struct packed {
    alu_op_e        alu_operator;
    op_a_sel_e      op_a_sel;
    op_b_sel_e      op_b_sel;
    op_c_sel_e      op_c_sel;
    imm_b_sel_e     imm_b_sel;
    logic           rf_we;
    ctrl_transfer_e ctrl_transfer;
    logic           illegal_insn;
  } decode_t;

  typedef struct packed {
    word_t operand_a;
    word_t operand_b;
    word_t operand_c;
  } operands_t;

  typedef struct packed {
    logic      instr_valid;
    word_t     pc;
    word_t     instr;
    alu_op_e   alu_operator;
    word_t     alu_operand_a;
    word_t     alu_operand_b;
    word_t     operand_c;
    logic      rf_we;
    reg_addr_t rf_waddr;
    logic      branch_in_ex;
    logic      jump;
    logic      illegal_insn;
  } id_ex_pipe_t;

endpackage

/* hw/id_stage.sv */
// RV32I instruction decode stage top level
// Decoder and operand unit side by side, feeding the ID/EX register
`timescale 1ns/1ns

module id_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  id_pkg::if_id_pipe_t if_id_pipe_i,
  input  id_pkg::ctrl_byp_t   ctrl_byp_i,
  input  id_pkg::word_t       rf_rdata_a_i,
  input  id_pkg::word_t       rf_rdata_b_i,
  input  id_pkg::word_t       rf_wdata_ex_i,
  input  id_pkg::word_t       rf_wdata_wb_i,
  input  logic                kill_id_i,
  input  logic                ex_ready_i,
  output id_pkg::reg_addr_t   rf_raddr_a_o,
  output id_pkg::reg_addr_t   rf_raddr_b_o,
  output id_pkg::word_t       jmp_target_o,
  output logic                id_ready_o,
  output id_pkg::id_ex_pipe_t id_ex_pipe_o
);
  import id_pkg::*;

  decode_t   dec;
  operands_t ops;
  reg_addr_t rd;

  // Register fields
  assign rf_raddr_a_o = if_id_pipe_i.instr[REG_S1_MSB:REG_S1_LSB];
  assign rf_raddr_b_o = if_id_pipe_i.instr[REG_S2_MSB:REG_S2_LSB];
  assign rd           = if_id_pipe_i.instr[REG_D_MSB:REG_D_LSB];

  id_decoder i_decoder (
    .instr_i (if_id_pipe_i.instr),
    .dec_o   (dec)
  );

  id_operand_unit i_operand_unit (
    .dec_i         (dec),
    .instr_i       (if_id_pipe_i.instr),
    .pc_i          (if_id_pipe_i.pc),
    .byp_i         (ctrl_byp_i),
    .rf_rdata_a_i  (rf_rdata_a_i),
    .rf_rdata_b_i  (rf_rdata_b_i),
    .rf_wdata_ex_i (rf_wdata_ex_i),
    .rf_wdata_wb_i (rf_wdata_wb_i),
    .ops_o         (ops),
    .jmp_target_o  (jmp_target_o)
  );

  id_ex_register i_id_ex_register (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec_i      (dec),
    .ops_i      (ops),
    .if_id_i    (if_id_pipe_i),
    .rd_i       (rd),
    .kill_id_i  (kill_id_i),
    .ex_ready_i (ex_ready_i),
    .id_ready_o (id_ready_o),
    .pipe_o     (id_ex_pipe_o)
  );

endmodule

/* id_stage.f */
+incdir+bench
hw/id_pkg.sv
hw/id_decoder.sv
hw/id_operand_unit.sv
hw/id_ex_register.sv
hw/id_stage.sv
bench/id_stage_tb.sv

/* run.sh */
#!/bin/sh
# Compile the decode stage testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module id_stage_tb -Mdir obj_dir -o id_stage_sim \
  -f id_stage.f

out=$(./obj_dir/id_stage_sim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qF '*** PASSED ***'; then
  exit 0
else
  echo "Simulation did not pass"
  exit 1
fi
